// File: verilog/mipsFetchPkg.sv
package mipsFetchPkg;

  // Instruction memory geometry
  localparam int IMEM_WORDS = 512;                  // Words in the array
  localparam int IMEM_AW    = $clog2(IMEM_WORDS);   // Word address width, 9 bits

  // APB register map
  localparam int APB_AW = 12;                        // Byte address width on APB

  localparam logic [APB_AW-1:0] REG_CTRL     = 12'h000; // Bit 0 is run
  localparam logic [APB_AW-1:0] REG_BOOTPC   = 12'h004; // PC loaded when fetch starts
  localparam logic [APB_AW-1:0] REG_FETCHCNT = 12'h008; // Delivered count, read only
  localparam logic [APB_AW-1:0] IMEM_BASE    = 12'h800; // Memory window 0x800..0xFFF

  // Opcodes resolved or predicted in fetch
  localparam logic [5:0] OP_J   = 6'd2;  // Jump
  localparam logic [5:0] OP_JAL = 6'd3;  // Jump and link, same target rule
  localparam logic [5:0] OP_BEQ = 6'd4;  // Branch if equal
  localparam logic [5:0] OP_BNE = 6'd5;  // Branch if not equal

  // J format view of a word
  typedef struct packed {
    logic [5:0]  op;      // Opcode
    logic [25:0] target;  // Word index inside the 256 MB region
  } mipsJType_s;

  // I format view of a word
  typedef struct packed {
    logic [5:0]  op;   // Opcode
    logic [4:0]  rs;   // Source register
    logic [4:0]  rt;   // Second source or destination
    logic [15:0] imm;  // Signed word offset for branches
  } mipsIType_s;

  // One fetched word, read both ways by the sequencer
  typedef union packed {
    mipsJType_s jType;  // Jump target decode
    mipsIType_s iType;  // Branch offset decode
  } mipsInstr_u;

endpackage

// File: verilog/imemIf.sv
interface imemIf
  import mipsFetchPkg::*;
();

  logic               hostEn;     // Access strobe, one cycle per word
  logic               hostWe;     // High for write, low for read
  logic [IMEM_AW-1:0] hostAddr;   // Word address
  logic [31:0]        hostWData;  // Stored at the edge with hostEn and hostWe
  logic [31:0]        hostRData;  // Valid the cycle after a read strobe

  // APB side drives the strobe, address and data
  modport host (
    output hostEn, hostWe, hostAddr, hostWData,
    input  hostRData
  );

  // Memory side answers with read data
  modport mem (
    input  hostEn, hostWe, hostAddr, hostWData,
    output hostRData
  );

endinterface

// File: verilog/InstructionMemory.sv
module InstructionMemory
  import mipsFetchPkg::*;
(
  input  logic               clk,
  input  logic [IMEM_AW-1:0] fetchAddr,  // Word address from the sequencer
  input  logic               stall,      // Holds the fetch output register
  output mipsInstr_u         fetchData,  // Registered fetch word
  imemIf.mem                 host        // Loader port from the APB bridge
);

  // Program storage, loaded only through the host port
  logic [31:0] memArray [IMEM_WORDS];

  // Fetch read port
  // The output register only moves when the pipeline is not stalled,
  // so a stalled decode stage keeps seeing the same word
  always_ff @(posedge clk) begin
    if (!stall) begin
      fetchData <= memArray[fetchAddr];  // Word at the address issued this cycle
    end
  end

  // Host port, one access per strobe
  always_ff @(posedge clk) begin
    if (host.hostEn) begin
      if (host.hostWe) begin
        memArray[host.hostAddr] <= host.hostWData;  // Program load
      end else begin
        host.hostRData <= memArray[host.hostAddr];  // Readback, one cycle later
      end
    end
  end

  // A host write and a fetch read to the same word in one cycle
  // give the old word on the fetch side
  // The bridge only loads while fetch is stopped, so this does not arise
  // in normal use

endmodule

// File: verilog/ApbImemBridge.sv
module ApbImemBridge
  import mipsFetchPkg::*;
(
  input  logic              clk,
  input  logic              arstN,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [APB_AW-1:0] paddr,
  input  logic [31:0]       pwdata,
  input  logic [31:0]       fetchCount,  // Delivered count from the sequencer
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  output logic              run,         // Fetch enable
  output logic [31:0]       bootPc,      // Start address for fetch
  imemIf.host               host         // Memory load and readback port
);

  logic access;    // APB access phase
  logic inWindow;  // Address falls in the memory window
  logic regHit;    // Address is one of the control registers
  logic refuse;    // Transfer ends with pslverr and no effect
  logic memRead;   // Window read that goes to the memory
  logic readWait;  // Second access cycle of a window read

  assign access   = psel && penable;
  assign inWindow = paddr >= IMEM_BASE;
  assign regHit   = paddr inside {REG_CTRL, REG_BOOTPC, REG_FETCHCNT};

  // Window is locked while fetching, anything else off the map is an error
  assign refuse  = inWindow ? run : !regHit;
  assign memRead = access && inWindow && !pwrite && !run;

  // Memory reads wait one cycle for hostRData, everything else is zero wait
  assign pready  = access && (!memRead || readWait);
  assign pslverr = pready && refuse;

  // Host port strobes in the first access cycle only
  assign host.hostEn    = access && inWindow && !run && !readWait;
  assign host.hostWe    = pwrite;
  assign host.hostAddr  = paddr[IMEM_AW+1:2];  // Word select, byte lanes ignored
  assign host.hostWData = pwdata;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      readWait <= 1'b0;
    end else begin
      readWait <= memRead && !readWait;  // Set for exactly one cycle
    end
  end

  // Control register writes
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      run    <= 1'b0;
      bootPc <= '0;
    end else if (access && pwrite && !refuse) begin
      case (paddr)
        REG_CTRL:   run    <= pwdata[0];
        REG_BOOTPC: bootPc <= pwdata;
        default:    ;                      // Count is read only, window writes go to host
      endcase
    end
  end

  // Read mux
  always_comb begin
    prdata = '0;
    if (!refuse) begin
      if (inWindow) begin
        prdata = host.hostRData;           // Valid in the completing cycle
      end else begin
        case (paddr)
          REG_CTRL:     prdata = {31'b0, run};
          REG_BOOTPC:   prdata = bootPc;
          REG_FETCHCNT: prdata = fetchCount;
          default:      prdata = '0;
        endcase
      end
    end
  end

endmodule

// File: verilog/FetchSequencer.sv
module FetchSequencer
  import mipsFetchPkg::*;
(
  input  logic               clk,
  input  logic               arstN,
  input  logic               run,         // Fetch enable from the bridge
  input  logic [31:0]        bootPc,      // Start address
  input  logic               stall,       // Back-pressure from decode
  input  logic               redirect,    // Misprediction fix from execute
  input  logic [31:0]        redirectPc,  // Corrected address
  input  mipsInstr_u         fetchData,   // Word in the memory output register
  output logic [IMEM_AW-1:0] fetchAddr,   // Word address issued this cycle
  output logic [31:0]        instrPc,     // PC of the delivered word
  output logic               instrValid,  // Delivered word is on the correct path
  output logic [31:0]        fetchCount   // Delivered instructions
);

  logic [31:0] seqPc;         // Issue address when nothing is predicted
  logic [31:0] issuePc;       // Address sent to memory this cycle
  logic [31:0] pcPlus4;       // Fall-through of the delivered word
  logic [31:0] jumpTarget;    // J and JAL target
  logic [31:0] branchOffset;  // Sign-extended word offset in bytes
  logic [31:0] branchTarget;  // Taken BEQ or BNE target
  logic        isJump;        // Delivered word is a valid J or JAL
  logic        isBackBranch;  // Delivered word is a valid backward BEQ or BNE

  // Decode the delivered word both ways
  assign pcPlus4 = instrPc + 32'd4;

  assign isJump = instrValid &&
                  (fetchData.jType.op == OP_J || fetchData.jType.op == OP_JAL);

  assign isBackBranch = instrValid &&
                        (fetchData.iType.op == OP_BEQ || fetchData.iType.op == OP_BNE) &&
                        fetchData.iType.imm[15];  // Negative offset, predict taken

  assign jumpTarget   = {pcPlus4[31:28], fetchData.jType.target, 2'b00};
  assign branchOffset = {{14{fetchData.iType.imm[15]}}, fetchData.iType.imm, 2'b00};
  assign branchTarget = pcPlus4 + branchOffset;

  // Prediction overrides the sequential address in the same cycle
  // so the target is delivered right behind the jump or branch
  always_comb begin
    if (isJump) begin
      issuePc = jumpTarget;
    end else if (isBackBranch) begin
      issuePc = branchTarget;
    end else begin
      issuePc = seqPc;              // Forward branches fall through
    end
  end

  assign fetchAddr = issuePc[IMEM_AW+1:2];  // Word index into the 512-word memory

  // PC and the record of the word now in the memory output register
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      seqPc      <= '0;
      instrPc    <= '0;
      instrValid <= 1'b0;
    end else if (!run) begin
      seqPc      <= bootPc;         // Parked on the boot PC, loaded on the run edge
      instrValid <= 1'b0;           // Stop drops the delivered word
    end else if (!stall) begin
      instrPc <= issuePc;           // Follows the word into the memory register
      if (redirect) begin
        seqPc      <= redirectPc;   // Issued next cycle
        instrValid <= 1'b0;         // Squash the wrong-path word issued now
      end else begin
        seqPc      <= issuePc + 32'd4;
        instrValid <= 1'b1;
      end
    end
  end

  // Delivered count, a word is handed over when valid and not held
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      fetchCount <= '0;
    end else if (instrValid && !stall) begin
      fetchCount <= fetchCount + 32'd1;
    end
  end

endmodule

// File: verilog/FetchUnit.sv
module FetchUnit
  import mipsFetchPkg::*;
(
  input  logic              clk,
  input  logic              arstN,

  // APB slave, host loads programs and controls fetch
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [APB_AW-1:0] paddr,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,

  // Pipeline side
  input  logic              stall,       // Hold from a later stage
  input  logic              redirect,    // Execute-stage correction
  input  logic [31:0]       redirectPc,
  output logic [31:0]       instr,       // Word handed to decode
  output logic [31:0]       instrPc,
  output logic              instrValid
);

  logic               run;         // Fetch enable
  logic [31:0]        bootPc;      // Start address
  logic [31:0]        fetchCount;  // Delivered instructions
  logic [IMEM_AW-1:0] fetchAddr;   // Issued word address
  mipsInstr_u         fetchData;   // Memory output register

  imemIf hostBus ();               // Loader path, bridge to memory

  ApbImemBridge ApbImemBridge_inst (
    .clk        (clk),
    .arstN      (arstN),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .fetchCount (fetchCount),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .run        (run),
    .bootPc     (bootPc),
    .host       (hostBus)
  );

  InstructionMemory InstructionMemory_inst (
    .clk       (clk),
    .fetchAddr (fetchAddr),
    .stall     (stall),
    .fetchData (fetchData),
    .host      (hostBus)
  );

  FetchSequencer FetchSequencer_inst (
    .clk        (clk),
    .arstN      (arstN),
    .run        (run),
    .bootPc     (bootPc),
    .stall      (stall),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .fetchData  (fetchData),
    .fetchAddr  (fetchAddr),
    .instrPc    (instrPc),
    .instrValid (instrValid),
    .fetchCount (fetchCount)
  );

  assign instr = fetchData;  // Raw word, decode does its own field split

endmodule

// File: tb/FetchUnitTb.sv
module FetchUnitTb
  import mipsFetchPkg::*;
();

  localparam int RAND_WORDS   = 32;   // Random overwrites in the load test
  localparam int SEQ_CYCLES   = 300;
  localparam int JUMP_CYCLES  = 400;
  localparam int REDIR_CYCLES = 400;
  localparam int STALL_CYCLES = 400;
  // Two full loads at 3 cycles a write plus random accesses, runs and control transfers
  localparam int TOTAL_CYCLES = 2 * IMEM_WORDS * 3 + RAND_WORDS * 7 + SEQ_CYCLES +
                                JUMP_CYCLES + REDIR_CYCLES + STALL_CYCLES + 200;

  logic              clk;
  logic              arstN;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_AW-1:0] paddr;
  logic [31:0]       pwdata;
  logic [31:0]       prdata;
  logic              pready;
  logic              pslverr;
  logic              stall;
  logic              redirect;
  logic [31:0]       redirectPc;
  logic [31:0]       instr;
  logic [31:0]       instrPc;
  logic              instrValid;

  // Reference model state
  logic [31:0] modelMem [IMEM_WORDS];  // Mirror of the program memory
  logic        mRun;                   // Run bit as the sequencer sees it
  logic        mValid;                 // Expected instrValid
  logic [31:0] mPc;                    // Expected instrPc when valid
  logic [31:0] mNextPc;                // Next word after an invalid cycle
  logic [31:0] mBootPc;
  logic [31:0] mCount;                 // Expected delivered count
  logic        frozen;                 // Last edge was a stall while running

  logic [31:0] prevInstr;
  logic [31:0] prevPc;
  logic        prevValid;
  logic        havePrev = 1'b0;

  int    errCount = 0;
  int    checkCount = 0;
  int    testCount = 0;
  int    failCount = 0;
  int    testErrStart = 0;
  string testName = "reset";

  FetchUnit FetchUnit_inst (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    assert (actual === expected) else begin
      $display("[ERROR] %s %s: expected %h, actual %h", testName, what, expected, actual);
      errCount++;
    end
  endtask

  // Next PC after a valid delivered word
  function automatic logic [31:0] nextFetchPc(input logic [31:0] pc);
    logic [31:0] w;
    logic [31:0] pc4;
    w   = modelMem[pc[IMEM_AW+1:2]];
    pc4 = pc + 32'd4;
    if (w[31:26] == OP_J || w[31:26] == OP_JAL) begin
      return (pc4 & 32'hF000_0000) | (32'(w[25:0]) * 32'd4);  // Stays in the 256 MB region
    end
    if ((w[31:26] == OP_BEQ || w[31:26] == OP_BNE) && w[15]) begin
      return pc4 - (32'h0001_0000 - 32'(w[15:0])) * 32'd4;  // Backward taken
    end
    return pc4;
  endfunction

  // Model steps on every edge with the inputs driven in the cycle before
  always @(posedge clk) begin
    if (!arstN) begin
      mRun    = 1'b0;
      mValid  = 1'b0;
      mPc     = '0;
      mNextPc = '0;
      mBootPc = '0;
      mCount  = '0;
      frozen  = 1'b0;
    end else begin
      if (mValid && !stall) mCount = mCount + 32'd1;
      frozen = mRun && stall;
      if (!mRun) begin
        mValid  = 1'b0;
        mNextPc = mBootPc;               // Start fetches from the boot PC
      end else if (!stall) begin
        if (redirect) begin
          mValid  = 1'b0;                // One squashed cycle
          mNextPc = redirectPc;
        end else if (mValid) begin
          mPc = nextFetchPc(mPc);
        end else begin
          mPc    = mNextPc;
          mValid = 1'b1;
        end
      end
      if (psel && penable && pwrite) begin
        if (paddr == REG_CTRL) begin
          mRun = pwdata[0];
        end else if (paddr == REG_BOOTPC) begin
          mBootPc = pwdata;
        end else if (paddr >= IMEM_BASE && !mRun) begin
          modelMem[paddr[IMEM_AW+1:2]] = pwdata;  // Window locked while running
        end
      end
    end
  end

  // Outputs compared mid-cycle where they are stable
  always @(negedge clk) begin
    if (arstN) begin
      if (frozen && havePrev) begin
        checkValue("held instr", prevInstr, instr);
        checkValue("held instrPc", prevPc, instrPc);
        checkValue("held instrValid", {31'b0, prevValid}, {31'b0, instrValid});
      end
      checkValue("instrValid", {31'b0, mValid}, {31'b0, instrValid});
      if (mValid) begin
        checkValue("instrPc", mPc, instrPc);
        checkValue("instr", modelMem[mPc[IMEM_AW+1:2]], instr);
      end
      prevInstr = instr;
      prevPc    = instrPc;
      prevValid = instrValid;
      havePrev  = 1'b1;
    end
  end

  task automatic apbTransfer(input logic write, input logic [APB_AW-1:0] addr,
                             input logic [31:0] data, output logic [31:0] rdata,
                             output logic err, output int waits);
    @(posedge clk);
    #10;
    psel    = 1'b1;                      // Setup phase
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #10;
    penable = 1'b1;                      // Access phase
    waits   = 0;
    @(negedge clk);
    while (!pready && waits < 8) begin
      waits++;
      @(negedge clk);
    end
    assert (pready) else begin
      $display("%s: APB slave never raised pready at address %h", testName, addr);
      errCount++;
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #10;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apbWrite(input logic [APB_AW-1:0] addr, input logic [31:0] data,
                          input logic expErr);
    logic [31:0] rdata;
    logic        err;
    int          waits;
    apbTransfer(1'b1, addr, data, rdata, err, waits);
    checkValue("write pslverr", {31'b0, expErr}, {31'b0, err});
    checkValue("write wait cycles", 32'd0, 32'(waits));
  endtask

  task automatic apbRead(input logic [APB_AW-1:0] addr, input logic expErr,
                         input int expWaits, output logic [31:0] rdata);
    logic err;
    int   waits;
    apbTransfer(1'b0, addr, 32'd0, rdata, err, waits);
    checkValue("read pslverr", {31'b0, expErr}, {31'b0, err});
    checkValue("read wait cycles", 32'(expWaits), 32'(waits));
  endtask

  function automatic logic [APB_AW-1:0] windowAddr(input logic [IMEM_AW-1:0] idx);
    return IMEM_BASE + {1'b0, idx, 2'b00};
  endfunction

  // Any opcode except the ones fetch resolves
  function automatic logic [31:0] randomAlu();
    logic [31:0] w;
    w = $urandom;
    if (w[31:26] inside {OP_J, OP_JAL, OP_BEQ, OP_BNE}) w[31:26] = 6'd0;
    return w;
  endfunction

  function automatic logic [31:0] randomMixed();
    logic [31:0] w;
    int          pick;
    w    = randomAlu();
    pick = $urandom % 100;
    if (pick < 14) begin
      w[31:26] = OP_J;
    end else if (pick < 20) begin
      w[31:26] = OP_JAL;
    end else if (pick < 30) begin
      w[31:26] = pick[0] ? OP_BEQ : OP_BNE;
      w[15:0]  = 16'(-(2 + $urandom % 16));  // Short backward loop
    end else if (pick < 40) begin
      w[31:26] = pick[0] ? OP_BNE : OP_BEQ;
      w[15:0]  = 16'(1 + $urandom % 200);    // Forward offset falls through
    end
    return w;
  endfunction

  task automatic loadProgram(input bit mixed);
    for (int a = 0; a < IMEM_WORDS; a++) begin
      apbWrite(windowAddr(IMEM_AW'(a)), mixed ? randomMixed() : randomAlu(), 1'b0);
    end
  endtask

  task automatic startRun();
    apbWrite(REG_BOOTPC, $urandom & 32'hFFFF_FFFC, 1'b0);
    apbWrite(REG_CTRL, 32'd1, 1'b0);
  endtask

  task automatic runCycles(input int cycles, input int stallPct, input int redirectPct);
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      #10;
      stall      = ($urandom % 100) < stallPct;
      redirect   = ($urandom % 100) < redirectPct;
      redirectPc = $urandom & 32'hFFFF_FFFC;
    end
    @(posedge clk);
    #10;
    stall    = 1'b0;
    redirect = 1'b0;
  endtask

  task automatic startTest(input string name);
    testName     = name;
    testErrStart = errCount;
  endtask

  task automatic finishTest();
    int n;
    n = errCount - testErrStart;
    testCount++;
    if (n != 0) failCount++;
    $display("test %-22s %s (%0d errors)", testName, (n == 0) ? "PASS" : "FAIL", n);
  endtask

  initial begin
    logic [31:0]        seedVal;
    logic [31:0]        rdata;
    logic [IMEM_AW-1:0] addrList [RAND_WORDS];
    seedVal    = $urandom(53599);
    arstN      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    stall      = 1'b0;
    redirect   = 1'b0;
    redirectPc = '0;
    repeat (2) @(posedge clk);
    #10;
    arstN = 1'b1;

    startTest("load and readback");
    loadProgram(1'b0);
    for (int i = 0; i < RAND_WORDS; i++) begin
      addrList[i] = IMEM_AW'($urandom);
      apbWrite(windowAddr(addrList[i]), randomAlu(), 1'b0);
    end
    for (int i = 0; i < RAND_WORDS; i++) begin
      apbRead(windowAddr(addrList[i]), 1'b0, 1, rdata);   // One wait cycle for memory
      checkValue("readback", modelMem[addrList[i]], rdata);
    end
    apbWrite(12'h00C, 32'hDEAD_BEEF, 1'b1);                // Unmapped offsets
    apbRead(12'h010, 1'b1, 0, rdata);
    startRun();
    apbRead(REG_BOOTPC, 1'b0, 0, rdata);
    checkValue("boot PC readback", mBootPc, rdata);
    apbWrite(windowAddr(addrList[0]), ~modelMem[addrList[0]], 1'b1);  // Locked
    apbRead(windowAddr(addrList[0]), 1'b1, 0, rdata);
    apbWrite(REG_CTRL, 32'd0, 1'b0);
    apbRead(windowAddr(addrList[0]), 1'b0, 1, rdata);
    checkValue("word after locked write", modelMem[addrList[0]], rdata);
    finishTest();

    startTest("sequential fetch");
    startRun();
    runCycles(SEQ_CYCLES, 0, 0);
    apbWrite(REG_CTRL, 32'd0, 1'b0);
    finishTest();

    startTest("jumps and branches");
    loadProgram(1'b1);
    startRun();
    runCycles(JUMP_CYCLES, 0, 0);
    apbWrite(REG_CTRL, 32'd0, 1'b0);
    finishTest();

    startTest("redirect");
    startRun();
    runCycles(REDIR_CYCLES, 0, 12);
    apbWrite(REG_CTRL, 32'd0, 1'b0);
    finishTest();

    startTest("stall and count");
    startRun();
    runCycles(STALL_CYCLES, 30, 8);
    apbWrite(REG_CTRL, 32'd0, 1'b0);
    apbRead(REG_FETCHCNT, 1'b0, 0, rdata);
    checkValue("fetch count", mCount, rdata);
    finishTest();

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             testCount, failCount, checkCount, errCount);
    if (errCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog at twice the planned run length
  initial begin
    #(TOTAL_CYCLES * 100 * 2);
    $display("watchdog: tests still running after %0d cycles", TOTAL_CYCLES * 2);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: tb.f
verilog/mipsFetchPkg.sv
verilog/imemIf.sv
verilog/InstructionMemory.sv
verilog/ApbImemBridge.sv
verilog/FetchSequencer.sv
verilog/FetchUnit.sv
tb/FetchUnitTb.sv

// File: run.sh
#!/bin/sh
# Build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module FetchUnitTb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VFetchUnitTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
